// File: flist.f
rtl/csidhPkg.sv
rtl/exponentBank.sv
rtl/primeMultiplier.sv
rtl/cofactorEngine.sv
rtl/batchSequencer.sv
rtl/csidhScheduler.sv
verif/csidhScheduler_sva.sv
verif/csidhScheduler_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csidhScheduler_tb -f flist.f -o simv \
	&& ./obj_dir/simv \
	|| { echo "simulation failed"; exit 1; }

// File: verif/csidhScheduler_tb.sv
`timescale 1ns/1ns

module csidhScheduler_tb;
	import csidhPkg::*;

	localparam int BATCH_MAX = 16;
	localparam int MAX_BUDGET = 5;
	localparam int COF_W = 64;
	localparam int CW = NUM_PRIMES;
	// about 45 batches of 1900 cycles per run, 10 runs, plus margin
	localparam int CYCLE_LIMIT = 1200000;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [KEY_W-1:0] privateKey;
	logic busy;
	logic batchValid;
	logic batchSign;
	logic done;
	logic [NUM_PRIMES-1:0] batchMask;
	logic [COF_W-1:0] cofactor;

	int seed;
	int cycleCount = 0;
	int signOneBatches;
	int primes [NUM_PRIMES];
	int modelSign [NUM_PRIMES];
	int modelMag [NUM_PRIMES];
	int modelBudget [NUM_PRIMES];
	int uses [NUM_PRIMES];
	logic [KEY_W-1:0] key;

	csidhScheduler #(
		.BATCH_MAX(BATCH_MAX),
		.MAX_BUDGET(MAX_BUDGET),
		.COF_W(COF_W)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.privateKey(privateKey),
		.busy(busy),
		.batchValid(batchValid),
		.batchSign(batchSign),
		.done(done),
		.batchMask(batchMask),
		.cofactor(cofactor)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input string testName, input logic [CW-1:0] expected,
			input logic [CW-1:0] actual);
		if (expected !== actual) begin
			$display("** Error %s: expected %h, actual %h", testName, expected, actual);
			$display("TB FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// odd primes up to 733 by trial division, then 983
	function automatic void buildPrimes();
		int n;
		int d;
		int k;
		bit isPrime;
		k = 0;
		for (n = 3; n <= 733; n += 2) begin
			isPrime = 1'b1;
			for (d = 3; d * d <= n; d += 2) begin
				if (n % d == 0) isPrime = 1'b0;
			end
			if (isPrime) begin
				primes[k] = n;
				k++;
			end
		end
		primes[NUM_PRIMES-1] = 983;
	endfunction

	function automatic logic [KEY_W-1:0] randomKey();
		logic [KEY_W-1:0] k;
		logic [31:0] word;
		int w;
		k = '0;
		for (w = 0; w < (KEY_W + 31) / 32; w++) begin
			word = $random(seed);
			k = {k[KEY_W-33:0], word};
		end
		return k;
	endfunction

	// prime 0 takes the top nibble
	function automatic void decodeKey(input logic [KEY_W-1:0] k);
		logic [3:0] nib;
		int i;
		for (i = 0; i < NUM_PRIMES; i++) begin
			nib = k[4 * (NUM_PRIMES - 1 - i) +: 4];
			modelSign[i] = nib[3];
			modelMag[i] = nib[2:0];
			modelBudget[i] = MAX_BUDGET;
			uses[i] = 0;
		end
	endfunction

	function automatic int scanBatch(input int dir, output logic [NUM_PRIMES-1:0] mask);
		int i;
		int cnt;
		cnt = 0;
		mask = '0;
		for (i = 0; i < NUM_PRIMES && cnt < BATCH_MAX; i++) begin
			if (modelSign[i] == dir && modelBudget[i] > 0) begin
				mask[i] = 1'b1;
				cnt++;
			end
		end
		return cnt;
	endfunction

	function automatic logic [COF_W-1:0] expectedCofactor(input logic [NUM_PRIMES-1:0] mask);
		logic [COF_W-1:0] c;
		int i;
		c = 4;
		for (i = 0; i < NUM_PRIMES; i++) begin
			if (!mask[i]) c = c * COF_W'(primes[i]);
		end
		return c;
	endfunction

	function automatic void commitBatch(input logic [NUM_PRIMES-1:0] mask);
		int i;
		for (i = 0; i < NUM_PRIMES; i++) begin
			if (mask[i]) begin
				modelBudget[i]--;
				if (modelMag[i] > 0) modelMag[i]--;
			end
		end
	endfunction

	task automatic pulseStart(input logic [KEY_W-1:0] k);
		@(posedge clk);
		#1;
		start = 1'b1;
		privateKey = k;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic waitStrobe();
		@(negedge clk);
		while (!batchValid && !done) @(negedge clk);
	endtask

	// stopAfter of zero runs to done, otherwise returns after that many batches
	task automatic runKey(input logic [KEY_W-1:0] k, input string testName,
			input int stopAfter, input bit startWhileBusy);
		logic [NUM_PRIMES-1:0] expMask;
		int dir;
		int cnt;
		int batches;
		int i;
		bit finished;
		dir = 0;
		batches = 0;
		finished = 1'b0;
		signOneBatches = 0;
		decodeKey(k);
		pulseStart(k);
		while (!finished) begin
			cnt = scanBatch(dir, expMask);
			if (cnt == 0 && dir == 0) begin
				dir = 1;
			end else if (cnt == 0) begin
				waitStrobe();
				checkValue({testName, " done"}, CW'(1), CW'(done));
				checkValue({testName, " busy at done"}, CW'(0), CW'(busy));
				finished = 1'b1;
			end else begin
				waitStrobe();
				checkValue({testName, " batchValid"}, CW'(1), CW'(batchValid));
				checkValue({testName, " batchSign"}, CW'(dir), CW'(batchSign));
				checkValue({testName, " batchMask"}, expMask, batchMask);
				checkValue({testName, " cofactor"}, CW'(expectedCofactor(expMask)),
					CW'(cofactor));
				// reported members that carry their own sign
				for (i = 0; i < NUM_PRIMES; i++) begin
					if (batchMask[i] && batchSign == modelSign[i]) begin
						uses[i]++;
					end
				end
				commitBatch(expMask);
				batches++;
				if (batchSign) signOneBatches++;
				if (startWhileBusy && batches == 1) begin
					// a different key that must be ignored
					pulseStart(~k);
					checkValue({testName, " busy at second start"}, CW'(1), CW'(busy));
				end
				if (batches == stopAfter) finished = 1'b1;
			end
		end
		if (stopAfter == 0) begin
			for (i = 0; i < NUM_PRIMES; i++) begin
				checkValue($sformatf("%s uses of prime %0d", testName, i), CW'(MAX_BUDGET),
					CW'(uses[i]));
			end
		end
	endtask

	initial begin
		int r;
		seed = 41119;
		rst = 1'b1;
		start = 1'b0;
		privateKey = '0;
		buildPrimes();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		for (r = 0; r < 5; r++) begin
			key = randomKey();
			runKey(key, $sformatf("random key %0d", r), 0, 1'b0);
		end

		// all magnitudes zero, signs mixed
		key = randomKey() & {NUM_PRIMES{4'h8}};
		runKey(key, "dummy steps", 0, 1'b0);

		key = randomKey() & {NUM_PRIMES{4'h7}};
		runKey(key, "all sign 0", 0, 1'b0);
		checkValue("all sign 0 batches of sign 1", CW'(0), CW'(signOneBatches));

		key = randomKey();
		runKey(key, "start while busy", 0, 1'b1);

		// abort a run with reset, then a fresh one
		key = randomKey();
		runKey(key, "reset mid run", 3, 1'b0);
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		checkValue("busy after reset", CW'(0), CW'(busy));
		checkValue("done after reset", CW'(0), CW'(done));
		key = randomKey();
		runKey(key, "run after reset", 0, 1'b0);

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verif/csidhScheduler_sva.sv
`timescale 1ns/1ns

module csidhScheduler_sva #(
	parameter int BATCH_MAX = 16
) (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic batchValid,
	input logic done,
	input logic [csidhPkg::NUM_PRIMES-1:0] batchMask
);

	// result strobes never overlap
	validDoneExclusive: assert property (@(posedge clk) disable iff (rst)
		!(batchValid && done))
		else $error("batchValid and done high in the same cycle");

	// a reported batch holds between one and BATCH_MAX primes
	maskSize: assert property (@(posedge clk) disable iff (rst)
		batchValid |-> batchMask != '0 && $countones(batchMask) <= BATCH_MAX)
		else $error("batchMask empty or larger than BATCH_MAX");

	// single pulse, core idle afterwards
	donePulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done && !busy)
		else $error("done longer than one cycle or busy right after done");

endmodule

bind csidhScheduler csidhScheduler_sva #(
	.BATCH_MAX(BATCH_MAX)
) sva_i (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.batchValid(batchValid),
	.done(done),
	.batchMask(batchMask)
);

// File: rtl/csidhScheduler.sv
`timescale 1ns/1ns

module csidhScheduler #(
	parameter int BATCH_MAX = 16,
	parameter int MAX_BUDGET = 5,
	parameter int COF_W = 64
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [csidhPkg::KEY_W-1:0] privateKey,
	output logic busy,
	output logic batchValid,
	output logic batchSign,
	output logic done,
	output logic [csidhPkg::NUM_PRIMES-1:0] batchMask,
	output logic [COF_W-1:0] cofactor
);
	import csidhPkg::*;

	logic load;
	primeIdxT scanIdx;
	logic direction;
	logic eligible;
	logic commit;
	logic cofStart;
	logic cofDone;
	logic [COF_W-1:0] cofResult;
	logic mulStart;
	logic [COF_W-1:0] mulOperand;
	logic [PRIME_W-1:0] mulPrime;
	logic mulDone;
	logic [COF_W-1:0] mulProduct;

	// key goes straight to the bank, load marks the start cycle
	exponentBank #(
		.MAX_BUDGET(MAX_BUDGET)
	) bank_i (
		.clk(clk),
		.rst(rst),
		.load(load),
		.privateKey(privateKey),
		.scanIdx(scanIdx),
		.direction(direction),
		.eligible(eligible),
		.commit(commit),
		.commitMask(batchMask)
	);

	batchSequencer #(
		.BATCH_MAX(BATCH_MAX),
		.COF_W(COF_W)
	) seq_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.load(load),
		.scanIdx(scanIdx),
		.direction(direction),
		.eligible(eligible),
		.commit(commit),
		.batchMask(batchMask),
		.cofStart(cofStart),
		.cofDone(cofDone),
		.cofResult(cofResult),
		.batchValid(batchValid),
		.batchSign(batchSign),
		.cofactor(cofactor),
		.done(done)
	);

	cofactorEngine #(
		.COF_W(COF_W)
	) cof_i (
		.clk(clk),
		.rst(rst),
		.cofStart(cofStart),
		.mask(batchMask),
		.cofDone(cofDone),
		.cofResult(cofResult),
		.mulStart(mulStart),
		.mulOperand(mulOperand),
		.mulPrime(mulPrime),
		.mulDone(mulDone),
		.mulProduct(mulProduct)
	);

	primeMultiplier #(
		.COF_W(COF_W)
	) mul_i (
		.clk(clk),
		.rst(rst),
		.mulStart(mulStart),
		.mulOperand(mulOperand),
		.mulPrime(mulPrime),
		.mulDone(mulDone),
		.mulProduct(mulProduct)
	);

endmodule

// File: rtl/batchSequencer.sv
`timescale 1ns/1ns

module batchSequencer #(
	parameter int BATCH_MAX = 16,
	parameter int COF_W = 64
) (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	output logic load,
	output csidhPkg::primeIdxT scanIdx,
	output logic direction,
	input logic eligible,
	output logic commit,
	output logic [csidhPkg::NUM_PRIMES-1:0] batchMask,
	output logic cofStart,
	input logic cofDone,
	input logic [COF_W-1:0] cofResult,
	output logic batchValid,
	output logic batchSign,
	output logic [COF_W-1:0] cofactor,
	output logic done
);
	import csidhPkg::*;

	localparam int CNT_W = $clog2(BATCH_MAX + 1);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_LOAD = 3'd1;
	localparam logic [2:0] ST_SCAN = 3'd2;
	localparam logic [2:0] ST_WAIT = 3'd3;
	localparam logic [2:0] ST_REPORT = 3'd4;
	localparam logic [2:0] ST_FINISH = 3'd5;

	logic [2:0] state;
	logic [CNT_W-1:0] memberCnt;
	logic [NUM_PRIMES-1:0] scanMask;
	logic scanEnd;

	assign scanEnd = memberCnt == CNT_W'(BATCH_MAX) || scanIdx == primeIdxT'(NUM_PRIMES);

	// busy already low while done is shown
	assign busy = state != ST_IDLE && state != ST_FINISH;
	assign load = start && !busy;
	assign batchValid = state == ST_REPORT;
	assign commit = state == ST_REPORT;
	assign done = state == ST_FINISH;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			scanIdx <= '0;
			direction <= 1'b0;
			memberCnt <= '0;
			scanMask <= '0;
			cofStart <= 1'b0;
		end else begin
			cofStart <= 1'b0;
			case (state)
				ST_IDLE, ST_FINISH: begin
					state <= start ? ST_LOAD : ST_IDLE;
				end
				ST_LOAD: begin
					// digits are in the bank from here on
					scanIdx <= '0;
					direction <= 1'b0;
					memberCnt <= '0;
					scanMask <= '0;
					state <= ST_SCAN;
				end
				ST_SCAN: begin
					if (scanEnd) begin
						if (memberCnt != '0) begin
							batchMask <= scanMask;
							cofStart <= 1'b1;
							state <= ST_WAIT;
						end else if (!direction) begin
							// nothing left on this side, turn around
							direction <= 1'b1;
							scanIdx <= '0;
						end else begin
							state <= ST_FINISH;
						end
					end else begin
						if (eligible) begin
							scanMask[scanIdx] <= 1'b1;
							memberCnt <= memberCnt + 1'b1;
						end
						scanIdx <= scanIdx + 1'b1;
					end
				end
				ST_WAIT: begin
					if (cofDone) begin
						cofactor <= cofResult;
						batchSign <= direction;
						state <= ST_REPORT;
					end
				end
				ST_REPORT: begin
					// bank commits this cycle, rescan right after
					scanIdx <= '0;
					memberCnt <= '0;
					scanMask <= '0;
					state <= ST_SCAN;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: rtl/cofactorEngine.sv
`timescale 1ns/1ns

module cofactorEngine #(
	parameter int COF_W = 64
) (
	input logic clk,
	input logic rst,
	input logic cofStart,
	input logic [csidhPkg::NUM_PRIMES-1:0] mask,
	output logic cofDone,
	output logic [COF_W-1:0] cofResult,
	output logic mulStart,
	output logic [COF_W-1:0] mulOperand,
	output logic [csidhPkg::PRIME_W-1:0] mulPrime,
	input logic mulDone,
	input logic [COF_W-1:0] mulProduct
);
	import csidhPkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_STEP = 2'd1;
	localparam logic [1:0] ST_MUL = 2'd2;

	logic [1:0] state;
	primeIdxT idx;
	logic idxValid;
	logic [NUM_PRIMES-1:0] maskReg;
	logic [COF_W-1:0] acc;

	assign idxValid = idx < primeIdxT'(NUM_PRIMES);

	// primes outside the batch are multiplied in, one at a time
	assign mulStart = state == ST_STEP && idxValid && !maskReg[idx];
	assign mulOperand = acc;
	assign mulPrime = idxValid ? PRIME_TABLE[idx] : '0;
	assign cofResult = acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cofDone <= 1'b0;
			idx <= '0;
		end else begin
			cofDone <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cofStart) begin
						maskReg <= mask;
						acc <= COF_W'(COF_INIT);
						idx <= '0;
						state <= ST_STEP;
					end
				end
				ST_STEP: begin
					if (!idxValid) begin
						cofDone <= 1'b1;
						state <= ST_IDLE;
					end else if (maskReg[idx]) begin
						// batch member, skip it
						idx <= idx + 1'b1;
					end else begin
						state <= ST_MUL;
					end
				end
				ST_MUL: begin
					if (mulDone) begin
						acc <= mulProduct;
						idx <= idx + 1'b1;
						state <= ST_STEP;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: rtl/primeMultiplier.sv
`timescale 1ns/1ns

module primeMultiplier #(
	parameter int COF_W = 64
) (
	input logic clk,
	input logic rst,
	input logic mulStart,
	input logic [COF_W-1:0] mulOperand,
	input logic [csidhPkg::PRIME_W-1:0] mulPrime,
	output logic mulDone,
	output logic [COF_W-1:0] mulProduct
);
	import csidhPkg::*;

	localparam int BIT_CNT_W = $clog2(PRIME_W);

	logic running;
	logic [BIT_CNT_W-1:0] bitCnt;
	logic [COF_W-1:0] multiplicand;
	logic [PRIME_W-1:0] primeBits;
	logic [COF_W-1:0] acc;

	assign mulProduct = acc;

	// one prime bit per cycle, lsb first, top bits fall off
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			mulDone <= 1'b0;
			bitCnt <= '0;
		end else begin
			mulDone <= 1'b0;
			if (mulStart) begin
				running <= 1'b1;
				bitCnt <= '0;
				acc <= '0;
				multiplicand <= mulOperand;
				primeBits <= mulPrime;
			end else if (running) begin
				if (primeBits[0]) begin
					acc <= acc + multiplicand;
				end
				multiplicand <= multiplicand << 1;
				primeBits <= primeBits >> 1;
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == BIT_CNT_W'(PRIME_W - 1)) begin
					running <= 1'b0;
					mulDone <= 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/exponentBank.sv
`timescale 1ns/1ns

module exponentBank #(
	parameter int MAX_BUDGET = 5
) (
	input logic clk,
	input logic rst,
	input logic load,
	input logic [csidhPkg::KEY_W-1:0] privateKey,
	input csidhPkg::primeIdxT scanIdx,
	input logic direction,
	output logic eligible,
	input logic commit,
	input logic [csidhPkg::NUM_PRIMES-1:0] commitMask
);
	import csidhPkg::*;

	localparam int BUDGET_W = $clog2(MAX_BUDGET + 1);

	expDigitU digits [NUM_PRIMES];
	logic [BUDGET_W-1:0] budgets [NUM_PRIMES];

	primeIdxT readIdx;
	logic idxValid;

	// past the table end nothing is eligible
	assign idxValid = scanIdx < primeIdxT'(NUM_PRIMES);

	always_comb begin
		readIdx = idxValid ? scanIdx : '0;
		eligible = idxValid && digits[readIdx].sm.sign == direction &&
			budgets[readIdx] != '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_PRIMES; i++) begin
				budgets[i] <= '0;
			end
		end else if (load) begin
			// key nibbles are stored top first
			for (int i = 0; i < NUM_PRIMES; i++) begin
				digits[i].raw <= privateKey[4 * (NUM_PRIMES - 1 - i) +: 4];
				budgets[i] <= BUDGET_W'(MAX_BUDGET);
			end
		end else if (commit) begin
			for (int i = 0; i < NUM_PRIMES; i++) begin
				if (commitMask[i]) begin
					budgets[i] <= budgets[i] - 1'b1;
					// zero magnitude means this step was a dummy
					if (digits[i].sm.mag != 3'd0) begin
						digits[i].sm.mag <= digits[i].sm.mag - 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: rtl/csidhPkg.sv
package csidhPkg;

	// small odd primes of the class group action
	localparam int NUM_PRIMES = 130;
	localparam int PRIME_W = 12;

	// one nibble per prime, prime 0 sits in the top nibble
	localparam int KEY_W = 4 * NUM_PRIMES;

	// cofactor seed, covers the 2-torsion
	localparam int COF_INIT = 4;

	typedef logic [7:0] primeIdxT;

	// key nibble, raw as loaded or split into sign and magnitude
	typedef union packed {
		logic [3:0] raw;
		struct packed {
			logic sign;
			logic [2:0] mag;
		} sm;
	} expDigitU;

	// table order, 3 up to 733 and then 983
	localparam logic [PRIME_W-1:0] PRIME_TABLE [NUM_PRIMES] = '{
		12'd3, 12'd5, 12'd7, 12'd11, 12'd13, 12'd17, 12'd19, 12'd23, 12'd29, 12'd31,
		12'd37, 12'd41, 12'd43, 12'd47, 12'd53, 12'd59, 12'd61, 12'd67, 12'd71, 12'd73,
		12'd79, 12'd83, 12'd89, 12'd97, 12'd101, 12'd103, 12'd107, 12'd109, 12'd113,
		12'd127, 12'd131, 12'd137, 12'd139, 12'd149, 12'd151, 12'd157, 12'd163, 12'd167,
		12'd173, 12'd179, 12'd181, 12'd191, 12'd193, 12'd197, 12'd199, 12'd211, 12'd223,
		12'd227, 12'd229, 12'd233, 12'd239, 12'd241, 12'd251, 12'd257, 12'd263, 12'd269,
		12'd271, 12'd277, 12'd281, 12'd283, 12'd293, 12'd307, 12'd311, 12'd313, 12'd317,
		12'd331, 12'd337, 12'd347, 12'd349, 12'd353, 12'd359, 12'd367, 12'd373, 12'd379,
		12'd383, 12'd389, 12'd397, 12'd401, 12'd409, 12'd419, 12'd421, 12'd431, 12'd433,
		12'd439, 12'd443, 12'd449, 12'd457, 12'd461, 12'd463, 12'd467, 12'd479, 12'd487,
		12'd491, 12'd499, 12'd503, 12'd509, 12'd521, 12'd523, 12'd541, 12'd547, 12'd557,
		12'd563, 12'd569, 12'd571, 12'd577, 12'd587, 12'd593, 12'd599, 12'd601, 12'd607,
		12'd613, 12'd617, 12'd619, 12'd631, 12'd641, 12'd643, 12'd647, 12'd653, 12'd659,
		12'd661, 12'd673, 12'd677, 12'd683, 12'd691, 12'd701, 12'd709, 12'd719, 12'd727,
		12'd733, 12'd983
	};

endpackage
